// File: source/mem_bridge_pkg.sv
`default_nettype none

package mem_bridge_pkg;

    // bus widths
    localparam int addr_w      = 32;
    localparam int data_w      = 32;
    localparam int be_w        = 4;   // byte enables, active low
    localparam int sram_addr_w = 20;  // word address into each SRAM

    // address map
    localparam logic [addr_w-1:0] base_ram_lo    = 32'h8000_0000;
    localparam logic [addr_w-1:0] ext_ram_lo     = 32'h8040_0000;
    localparam logic [addr_w-1:0] ram_hi         = 32'h807f_ffff;
    localparam logic [addr_w-1:0] uart_data_addr = 32'hbfd0_03f8;
    localparam logic [addr_w-1:0] uart_stat_addr = 32'hbfd0_03fc;

    // serial status word layout
    localparam int stat_tx_ready_bit = 0;
    localparam int stat_rx_avail_bit = 1;

    // cycles per serial bit, kept short for simulation
    localparam logic [7:0] clks_per_bit = 8'd8;

    typedef logic [7:0] uart_byte_t;

endpackage

`default_nettype wire

// File: source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire                       clk_i,
    input  wire                       locked_i,
    input  wire                       rxd_i,
    output mem_bridge_pkg::uart_byte_t byte_o,
    output logic                      valid_o
);
    import mem_bridge_pkg::*;

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_e;

    rx_state_e  state_q;
    logic       rxd_meta_q;
    logic       rxd_q;
    logic [7:0] cyc_q;
    logic [2:0] bit_q;
    logic       bit_end;
    uart_byte_t shift_q;

    // two-flop synchronizer, idle line is high
    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            rxd_meta_q <= 1'b1;
            rxd_q      <= 1'b1;
        end else begin
            rxd_meta_q <= rxd_i;
            rxd_q      <= rxd_meta_q;
        end
    end

    assign bit_end = (cyc_q == clks_per_bit - 8'd1);

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            state_q <= st_idle;
            cyc_q   <= '0;
            bit_q   <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            case (state_q)
                st_idle: begin
                    cyc_q <= '0;
                    if (!rxd_q) state_q <= st_start;  // falling edge of start bit
                end
                st_start: begin
                    // half a bit in: still low means a real start bit
                    if (cyc_q == (clks_per_bit >> 1) - 8'd1) begin
                        cyc_q   <= '0;
                        bit_q   <= '0;
                        state_q <= rxd_q ? st_idle : st_data;
                    end else begin
                        cyc_q <= cyc_q + 8'd1;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        cyc_q <= '0;
                        bit_q <= bit_q + 3'd1;
                        if (bit_q == 3'd7) state_q <= st_stop;
                    end else begin
                        cyc_q <= cyc_q + 8'd1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        state_q <= st_idle;
                        valid_o <= rxd_q;  // framing error drops the byte
                    end else begin
                        cyc_q <= cyc_q + 8'd1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk_i) begin
        if (state_q == st_data && bit_end) shift_q <= {rxd_q, shift_q[7:1]};
    end

    assign byte_o = shift_q;

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                       clk_i,
    input  wire                       locked_i,
    input  wire                       start_i,
    input  mem_bridge_pkg::uart_byte_t byte_i,
    output logic                      txd_o,
    output logic                      busy_o
);
    import mem_bridge_pkg::*;

    logic [9:0] frame_q;  // stop, data, start
    logic [7:0] cyc_q;
    logic [3:0] bit_q;
    logic       bit_end;

    assign bit_end = (cyc_q == clks_per_bit - 8'd1);

    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            busy_o <= 1'b0;
            cyc_q  <= '0;
            bit_q  <= '0;
        end else if (!busy_o) begin
            if (start_i) begin
                busy_o <= 1'b1;
                cyc_q  <= '0;
                bit_q  <= '0;
            end
        end else if (bit_end) begin
            cyc_q <= '0;
            bit_q <= bit_q + 4'd1;
            if (bit_q == 4'd9) busy_o <= 1'b0;  // end of stop bit
        end else begin
            cyc_q <= cyc_q + 8'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!busy_o && start_i) begin
            frame_q <= {1'b1, byte_i, 1'b0};
        end else if (busy_o && bit_end) begin
            frame_q <= {1'b1, frame_q[9:1]};
        end
    end

    // line idles high between frames
    assign txd_o = busy_o ? frame_q[0] : 1'b1;

endmodule

`default_nettype wire

// File: source/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  wire                       clk_i,
    input  wire                       locked_i,
    input  wire                       rxd_i,
    output logic                      txd_o,
    input  wire                       tx_start_i,
    input  mem_bridge_pkg::uart_byte_t tx_byte_i,
    input  wire                       rx_pop_i,
    output logic                      tx_ready_o,
    output logic                      rx_avail_o,
    output mem_bridge_pkg::uart_byte_t rx_byte_o
);
    import mem_bridge_pkg::*;

    uart_byte_t rx_data;
    logic       rx_valid;
    logic       tx_busy;

    uart_rx i_uart_rx (
        .clk_i    (clk_i),
        .locked_i (locked_i),
        .rxd_i    (rxd_i),
        .byte_o   (rx_data),
        .valid_o  (rx_valid)
    );

    uart_tx i_uart_tx (
        .clk_i    (clk_i),
        .locked_i (locked_i),
        .start_i  (tx_start_i),
        .byte_i   (tx_byte_i),
        .txd_o    (txd_o),
        .busy_o   (tx_busy)
    );

    // newer byte wins over a pop in the same cycle
    always_ff @(posedge clk_i or negedge locked_i) begin
        if (!locked_i) begin
            rx_avail_o <= 1'b0;
        end else if (rx_valid) begin
            rx_avail_o <= 1'b1;
        end else if (rx_pop_i) begin
            rx_avail_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_valid) rx_byte_o <= rx_data;  // one-byte buffer
    end

    assign tx_ready_o = ~tx_busy;

endmodule

`default_nettype wire

// File: source/mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bridge (
    // fetch port
    input  wire  [mem_bridge_pkg::addr_w-1:0]      ifu_addr_i,
    output logic [mem_bridge_pkg::data_w-1:0]      ifu_rdata_o,
    output logic                                   ifu_resp_o,
    // data port
    input  wire                                    lsu_req_i,
    input  wire                                    lsu_we_i,
    input  wire  [mem_bridge_pkg::addr_w-1:0]      lsu_addr_i,
    input  wire  [mem_bridge_pkg::data_w-1:0]      lsu_wdata_i,
    input  wire  [mem_bridge_pkg::be_w-1:0]        lsu_be_n_i,
    output logic [mem_bridge_pkg::data_w-1:0]      lsu_rdata_o,
    output logic                                   lsu_resp_o,
    // base RAM
    output logic [mem_bridge_pkg::sram_addr_w-1:0] base_ram_addr_o,
    output logic [mem_bridge_pkg::data_w-1:0]      base_ram_wdata_o,
    input  wire  [mem_bridge_pkg::data_w-1:0]      base_ram_rdata_i,
    output logic [mem_bridge_pkg::be_w-1:0]        base_ram_be_n_o,
    output logic                                   base_ram_ce_n_o,
    output logic                                   base_ram_oe_n_o,
    output logic                                   base_ram_we_n_o,
    // ext RAM
    output logic [mem_bridge_pkg::sram_addr_w-1:0] ext_ram_addr_o,
    output logic [mem_bridge_pkg::data_w-1:0]      ext_ram_wdata_o,
    input  wire  [mem_bridge_pkg::data_w-1:0]      ext_ram_rdata_i,
    output logic [mem_bridge_pkg::be_w-1:0]        ext_ram_be_n_o,
    output logic                                   ext_ram_ce_n_o,
    output logic                                   ext_ram_oe_n_o,
    output logic                                   ext_ram_we_n_o,
    // serial registers
    input  wire                                    tx_ready_i,
    input  wire                                    rx_avail_i,
    input  mem_bridge_pkg::uart_byte_t             rx_byte_i,
    output logic                                   tx_start_o,
    output logic                                   rx_pop_o,
    output mem_bridge_pkg::uart_byte_t             tx_byte_o
);
    import mem_bridge_pkg::*;

    logic              ifu_base;
    logic              lsu_base;
    logic              lsu_ext;
    logic              lsu_udata;
    logic              lsu_ustat;
    logic              lsu_be_sel;
    logic [be_w-1:0]   lsu_be_n;
    logic [data_w-1:0] stat_word;

    assign ifu_base  = (ifu_addr_i >= base_ram_lo) && (ifu_addr_i < ext_ram_lo);
    assign lsu_base  = lsu_req_i && (lsu_addr_i >= base_ram_lo) && (lsu_addr_i < ext_ram_lo);
    assign lsu_ext   = lsu_req_i && (lsu_addr_i >= ext_ram_lo) && (lsu_addr_i <= ram_hi);
    assign lsu_udata = lsu_req_i && (lsu_addr_i == uart_data_addr);
    assign lsu_ustat = lsu_req_i && (lsu_addr_i == uart_stat_addr);

    // reads fetch the whole word
    assign lsu_be_sel = lsu_we_i;
    assign lsu_be_n   = lsu_be_sel ? lsu_be_n_i : '0;

    // base RAM: data port wins, fetch waits a cycle
    always_comb begin
        if (lsu_base) begin
            base_ram_addr_o = lsu_addr_i[sram_addr_w+1:2];
            base_ram_be_n_o = lsu_be_n;
            base_ram_ce_n_o = 1'b0;
            base_ram_oe_n_o = lsu_we_i;
            base_ram_we_n_o = ~lsu_we_i;
        end else begin
            base_ram_addr_o = ifu_addr_i[sram_addr_w+1:2];
            base_ram_be_n_o = '0;
            base_ram_ce_n_o = ~ifu_base;
            base_ram_oe_n_o = ~ifu_base;
            base_ram_we_n_o = 1'b1;
        end
    end

    assign base_ram_wdata_o = lsu_wdata_i;
    assign ifu_resp_o       = ~lsu_base;
    assign ifu_rdata_o      = ifu_base ? base_ram_rdata_i : '0;

    // ext RAM belongs to the data port alone
    assign ext_ram_addr_o  = lsu_addr_i[sram_addr_w+1:2];
    assign ext_ram_wdata_o = lsu_wdata_i;
    assign ext_ram_be_n_o  = lsu_be_n;
    assign ext_ram_ce_n_o  = ~lsu_ext;
    assign ext_ram_oe_n_o  = ~(lsu_ext && !lsu_we_i);
    assign ext_ram_we_n_o  = ~(lsu_ext && lsu_we_i);

    always_comb begin
        stat_word                    = '0;
        stat_word[stat_tx_ready_bit] = tx_ready_i;
        stat_word[stat_rx_avail_bit] = rx_avail_i;
    end

    // serial write stalls while the transmitter is busy
    assign tx_start_o = lsu_udata && lsu_we_i && tx_ready_i;
    assign tx_byte_o  = lsu_wdata_i[7:0];
    assign rx_pop_o   = lsu_udata && !lsu_we_i;
    assign lsu_resp_o = ~(lsu_udata && lsu_we_i && !tx_ready_i);

    always_comb begin
        if (lsu_base) begin
            lsu_rdata_o = base_ram_rdata_i;
        end else if (lsu_ext) begin
            lsu_rdata_o = ext_ram_rdata_i;
        end else if (lsu_udata) begin
            lsu_rdata_o = {{(data_w-8){1'b0}}, rx_byte_i};
        end else if (lsu_ustat) begin
            lsu_rdata_o = stat_word;
        end else begin
            lsu_rdata_o = '0;  // unmapped reads as zero
        end
    end

endmodule

`default_nettype wire

// File: source/soc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_mem_top (
    input  wire                                    clk_i,
    input  wire                                    locked_i,
    input  wire                                    rxd_i,
    output logic                                   txd_o,
    input  wire  [mem_bridge_pkg::addr_w-1:0]      ifu_addr_i,
    output logic [mem_bridge_pkg::data_w-1:0]      ifu_rdata_o,
    output logic                                   ifu_resp_o,
    input  wire                                    lsu_req_i,
    input  wire                                    lsu_we_i,
    input  wire  [mem_bridge_pkg::addr_w-1:0]      lsu_addr_i,
    input  wire  [mem_bridge_pkg::data_w-1:0]      lsu_wdata_i,
    input  wire  [mem_bridge_pkg::be_w-1:0]        lsu_be_n_i,
    output logic [mem_bridge_pkg::data_w-1:0]      lsu_rdata_o,
    output logic                                   lsu_resp_o,
    output logic [mem_bridge_pkg::sram_addr_w-1:0] base_ram_addr_o,
    output logic [mem_bridge_pkg::data_w-1:0]      base_ram_wdata_o,
    input  wire  [mem_bridge_pkg::data_w-1:0]      base_ram_rdata_i,
    output logic [mem_bridge_pkg::be_w-1:0]        base_ram_be_n_o,
    output logic                                   base_ram_ce_n_o,
    output logic                                   base_ram_oe_n_o,
    output logic                                   base_ram_we_n_o,
    output logic [mem_bridge_pkg::sram_addr_w-1:0] ext_ram_addr_o,
    output logic [mem_bridge_pkg::data_w-1:0]      ext_ram_wdata_o,
    input  wire  [mem_bridge_pkg::data_w-1:0]      ext_ram_rdata_i,
    output logic [mem_bridge_pkg::be_w-1:0]        ext_ram_be_n_o,
    output logic                                   ext_ram_ce_n_o,
    output logic                                   ext_ram_oe_n_o,
    output logic                                   ext_ram_we_n_o
);
    import mem_bridge_pkg::*;

    // bridge to serial registers
    logic       tx_start;
    logic       rx_pop;
    logic       tx_ready;
    logic       rx_avail;
    uart_byte_t tx_byte;
    uart_byte_t rx_byte;

    mem_bridge i_mem_bridge (
        .ifu_addr_i       (ifu_addr_i),
        .ifu_rdata_o      (ifu_rdata_o),
        .ifu_resp_o       (ifu_resp_o),
        .lsu_req_i        (lsu_req_i),
        .lsu_we_i         (lsu_we_i),
        .lsu_addr_i       (lsu_addr_i),
        .lsu_wdata_i      (lsu_wdata_i),
        .lsu_be_n_i       (lsu_be_n_i),
        .lsu_rdata_o      (lsu_rdata_o),
        .lsu_resp_o       (lsu_resp_o),
        .base_ram_addr_o  (base_ram_addr_o),
        .base_ram_wdata_o (base_ram_wdata_o),
        .base_ram_rdata_i (base_ram_rdata_i),
        .base_ram_be_n_o  (base_ram_be_n_o),
        .base_ram_ce_n_o  (base_ram_ce_n_o),
        .base_ram_oe_n_o  (base_ram_oe_n_o),
        .base_ram_we_n_o  (base_ram_we_n_o),
        .ext_ram_addr_o   (ext_ram_addr_o),
        .ext_ram_wdata_o  (ext_ram_wdata_o),
        .ext_ram_rdata_i  (ext_ram_rdata_i),
        .ext_ram_be_n_o   (ext_ram_be_n_o),
        .ext_ram_ce_n_o   (ext_ram_ce_n_o),
        .ext_ram_oe_n_o   (ext_ram_oe_n_o),
        .ext_ram_we_n_o   (ext_ram_we_n_o),
        .tx_ready_i       (tx_ready),
        .rx_avail_i       (rx_avail),
        .rx_byte_i        (rx_byte),
        .tx_start_o       (tx_start),
        .rx_pop_o         (rx_pop),
        .tx_byte_o        (tx_byte)
    );

    uart_regs i_uart_regs (
        .clk_i      (clk_i),
        .locked_i   (locked_i),
        .rxd_i      (rxd_i),
        .txd_o      (txd_o),
        .tx_start_i (tx_start),
        .tx_byte_i  (tx_byte),
        .rx_pop_i   (rx_pop),
        .tx_ready_o (tx_ready),
        .rx_avail_o (rx_avail),
        .rx_byte_o  (rx_byte)
    );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int period_ns = 40
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(period_ns / 2) clk_o = ~clk_o;  // 50 % duty

endmodule

`default_nettype wire

// File: dv/tb_soc_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mem;
    import mem_bridge_pkg::*;

    localparam int num_tests       = 6;
    localparam int n_ext           = 8;
    localparam int frame_len       = 10 * int'(clks_per_bit);
    localparam int watchdog_cycles = num_tests * 12 * int'(clks_per_bit) + 200;
    localparam logic [data_w-1:0] ready_mask = data_w'(1) << stat_tx_ready_bit;
    localparam logic [data_w-1:0] avail_mask = data_w'(1) << stat_rx_avail_bit;

    logic                   clk;
    logic                   locked;
    logic                   txd;
    logic [addr_w-1:0]      ifu_addr;
    logic [data_w-1:0]      ifu_rdata;
    logic                   ifu_resp;
    logic                   lsu_req;
    logic                   lsu_we;
    logic [addr_w-1:0]      lsu_addr;
    logic [data_w-1:0]      lsu_wdata;
    logic [be_w-1:0]        lsu_be_n;
    logic [data_w-1:0]      lsu_rdata;
    logic                   lsu_resp;
    logic [sram_addr_w-1:0] base_addr;
    logic [data_w-1:0]      base_wdata;
    logic [data_w-1:0]      base_rdata;
    logic [be_w-1:0]        base_be_n;
    logic                   base_ce_n;
    logic                   base_oe_n;
    logic                   base_we_n;
    logic [sram_addr_w-1:0] ext_addr;
    logic [data_w-1:0]      ext_wdata;
    logic [data_w-1:0]      ext_rdata;
    logic [be_w-1:0]        ext_be_n;
    logic                   ext_ce_n;
    logic                   ext_oe_n;
    logic                   ext_we_n;

    logic [data_w-1:0] base_mem [0:(1 << sram_addr_w)-1];
    logic [data_w-1:0] ext_mem  [0:(1 << sram_addr_w)-1];
    logic [data_w-1:0] ext_shadow [logic [sram_addr_w-1:0]];  // expected ext RAM words
    logic [sram_addr_w-1:0] ext_idx_q [$];

    // check enables and expected values, driven along with the stimulus
    logic              chk_idle;
    logic              chk_fetch;
    logic              chk_arb;
    logic              chk_rd;
    logic              chk_stall;
    logic              chk_done;
    logic [data_w-1:0] exp_ifu;
    logic [data_w-1:0] exp_rd;
    logic [data_w-1:0] exp_mask;

    int     errors;
    int     accesses;
    integer seed;

    tb_clk_gen #(.period_ns(40)) i_tb_clk_gen (.clk_o(clk));

    soc_mem_top i_soc_mem_top (
        .clk_i            (clk),
        .locked_i         (locked),
        .rxd_i            (txd),  // serial loopback
        .txd_o            (txd),
        .ifu_addr_i       (ifu_addr),
        .ifu_rdata_o      (ifu_rdata),
        .ifu_resp_o       (ifu_resp),
        .lsu_req_i        (lsu_req),
        .lsu_we_i         (lsu_we),
        .lsu_addr_i       (lsu_addr),
        .lsu_wdata_i      (lsu_wdata),
        .lsu_be_n_i       (lsu_be_n),
        .lsu_rdata_o      (lsu_rdata),
        .lsu_resp_o       (lsu_resp),
        .base_ram_addr_o  (base_addr),
        .base_ram_wdata_o (base_wdata),
        .base_ram_rdata_i (base_rdata),
        .base_ram_be_n_o  (base_be_n),
        .base_ram_ce_n_o  (base_ce_n),
        .base_ram_oe_n_o  (base_oe_n),
        .base_ram_we_n_o  (base_we_n),
        .ext_ram_addr_o   (ext_addr),
        .ext_ram_wdata_o  (ext_wdata),
        .ext_ram_rdata_i  (ext_rdata),
        .ext_ram_be_n_o   (ext_be_n),
        .ext_ram_ce_n_o   (ext_ce_n),
        .ext_ram_oe_n_o   (ext_oe_n),
        .ext_ram_we_n_o   (ext_we_n)
    );

    // every address bit shows up in the word
    function automatic logic [data_w-1:0] fill_word(input logic ext,
                                                    input logic [sram_addr_w-1:0] idx);
        return {~idx[11:0], idx} ^ (ext ? 32'hc3c3_0000 : 32'h0000_0000);
    endfunction

    function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_w,
                                                      input logic [data_w-1:0] new_w,
                                                      input logic [be_w-1:0]   be_n);
        logic [data_w-1:0] w;
        int                b;
        w = old_w;
        for (b = 0; b < be_w; b++) begin
            if (!be_n[b]) w[b*8 +: 8] = new_w[b*8 +: 8];  // active-low enable
        end
        return w;
    endfunction

    function automatic logic [addr_w-1:0] ram_addr(input logic [addr_w-1:0] lo,
                                                   input logic [sram_addr_w-1:0] idx);
        return lo + {10'd0, idx, 2'b00};
    endfunction

    // asynchronous SRAM reads, writes taken at the clock edge
    assign base_rdata = (!base_ce_n && !base_oe_n) ? base_mem[base_addr] : '0;
    assign ext_rdata  = (!ext_ce_n && !ext_oe_n) ? ext_mem[ext_addr] : '0;

    always @(posedge clk) begin
        if (!base_ce_n && !base_we_n) begin
            base_mem[base_addr] <= merge_bytes(base_mem[base_addr], base_wdata, base_be_n);
        end
        if (!ext_ce_n && !ext_we_n) begin
            ext_mem[ext_addr] <= merge_bytes(ext_mem[ext_addr], ext_wdata, ext_be_n);
        end
    end

    a_idle: assert property (@(posedge clk)
        chk_idle |-> (txd && base_ce_n && ext_ce_n && base_we_n && ext_we_n))
        else begin
            errors++;
            $display("FAILED at %0t: idle pins txd=%b ce_n=%b%b we_n=%b%b", $time,
                     $sampled(txd), $sampled(base_ce_n), $sampled(ext_ce_n),
                     $sampled(base_we_n), $sampled(ext_we_n));
        end

    a_fetch: assert property (@(posedge clk)
        chk_fetch |-> (ifu_resp && ifu_rdata == exp_ifu))
        else begin
            errors++;
            $display("FAILED at %0t: fetch resp=%b data=%h, expected %h", $time,
                     $sampled(ifu_resp), $sampled(ifu_rdata), $sampled(exp_ifu));
        end

    a_arb: assert property (@(posedge clk) chk_arb |-> !ifu_resp)
        else begin
            errors++;
            $display("FAILED at %0t: fetch not held off by data access", $time);
        end

    a_rdata: assert property (@(posedge clk)
        chk_rd |-> (lsu_resp && (lsu_rdata & exp_mask) == exp_rd))
        else begin
            errors++;
            $display("FAILED at %0t: read of %h gave %h mask %h, expected %h", $time,
                     $sampled(lsu_addr), $sampled(lsu_rdata), $sampled(exp_mask),
                     $sampled(exp_rd));
        end

    a_stall: assert property (@(posedge clk) chk_stall |-> !lsu_resp)
        else begin
            errors++;
            $display("FAILED at %0t: serial write accepted while transmitter busy", $time);
        end

    a_done: assert property (@(posedge clk) chk_done |-> lsu_resp)
        else begin
            errors++;
            $display("FAILED at %0t: serial write still stalled after frame end", $time);
        end

    // only a serial write may see back-pressure
    a_backpressure: assert property (@(posedge clk) disable iff (!locked)
        (lsu_req && !lsu_resp) |-> (lsu_we && lsu_addr == uart_data_addr))
        else begin
            errors++;
            $display("FAILED at %0t: unexpected stall at %h", $time, $sampled(lsu_addr));
        end

    a_start_bit: assert property (@(posedge clk) disable iff (!locked)
        (lsu_req && lsu_we && lsu_addr == uart_data_addr && lsu_resp) |=> !txd)
        else begin
            errors++;
            $display("FAILED at %0t: no start bit after serial write", $time);
        end

    task automatic lsu_read(input logic [addr_w-1:0] addr, input logic [data_w-1:0] exp,
                            input logic [data_w-1:0] mask, input logic check,
                            output logic [data_w-1:0] data);
        lsu_req  <= 1'b1;
        lsu_we   <= 1'b0;
        lsu_addr <= addr;
        lsu_be_n <= '0;
        chk_rd   <= check;
        exp_rd   <= exp;
        exp_mask <= mask;
        @(posedge clk);
        while (!lsu_resp) @(posedge clk);
        data = lsu_rdata;
        chk_rd <= 1'b0;
        accesses++;
    endtask

    task automatic lsu_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata,
                             input logic [be_w-1:0] be_n);
        lsu_req   <= 1'b1;
        lsu_we    <= 1'b1;
        lsu_addr  <= addr;
        lsu_wdata <= wdata;
        lsu_be_n  <= be_n;
        @(posedge clk);
        while (!lsu_resp) @(posedge clk);
        accesses++;
    endtask

    task automatic fetch_check(input logic [sram_addr_w-1:0] idx);
        lsu_req   <= 1'b0;
        ifu_addr  <= ram_addr(base_ram_lo, idx);
        exp_ifu   <= fill_word(1'b0, idx);
        chk_fetch <= 1'b1;
        @(posedge clk);
        while (!ifu_resp) @(posedge clk);
        chk_fetch <= 1'b0;
    endtask

    // busy lasts one full frame from the edge that took the first byte
    task automatic stalled_serial_write(input uart_byte_t b);
        lsu_req   <= 1'b1;
        lsu_we    <= 1'b1;
        lsu_addr  <= uart_data_addr;
        lsu_wdata <= {{(data_w-8){1'b0}}, b};
        lsu_be_n  <= '0;
        chk_stall <= 1'b1;
        repeat (frame_len) @(posedge clk);
        chk_stall <= 1'b0;
        chk_done  <= 1'b1;
        @(posedge clk);
        while (!lsu_resp) @(posedge clk);
        chk_done <= 1'b0;
        lsu_req  <= 1'b0;
        accesses++;
    endtask

    initial begin
        logic [data_w-1:0]      rdata;
        logic [data_w-1:0]      wdata;
        logic [be_w-1:0]        be_n;
        logic [sram_addr_w-1:0] idx;
        logic [sram_addr_w:0]   a;
        uart_byte_t             tx_byte;
        int                     i;

        seed      = 32'he591_eadc;
        errors    = 0;
        accesses  = 0;
        locked    = 1'b0;
        ifu_addr  = '0;  // outside RAM so both chips stay deselected
        lsu_req   = 1'b0;
        lsu_we    = 1'b0;
        lsu_addr  = '0;
        lsu_wdata = '0;
        lsu_be_n  = '1;
        chk_idle  = 1'b0;
        chk_fetch = 1'b0;
        chk_arb   = 1'b0;
        chk_rd    = 1'b0;
        chk_stall = 1'b0;
        chk_done  = 1'b0;
        exp_ifu   = '0;
        exp_rd    = '0;
        exp_mask  = '0;
        for (a = '0; !a[sram_addr_w]; a = a + 1'b1) begin
            base_mem[a[sram_addr_w-1:0]] = fill_word(1'b0, a[sram_addr_w-1:0]);
            ext_mem[a[sram_addr_w-1:0]]  = fill_word(1'b1, a[sram_addr_w-1:0]);
        end

        @(posedge clk);
        chk_idle <= 1'b1;
        repeat (3) @(posedge clk);
        locked <= 1'b1;
        @(posedge clk);

        // pins and status straight after reset
        lsu_read(uart_stat_addr, ready_mask, '1, 1'b1, rdata);
        chk_idle <= 1'b0;

        for (i = 0; i < 4; i++) begin
            fetch_check(sram_addr_w'($random(seed)));
        end

        // data port takes base RAM from the fetch
        for (i = 0; i < 4; i++) begin
            idx      = sram_addr_w'($random(seed));
            idx[1:0] = 2'(i);
            wdata    = $random(seed);
            be_n     = be_w'($random(seed));
            ifu_addr <= ram_addr(base_ram_lo, sram_addr_w'($random(seed)));
            chk_arb  <= 1'b1;
            lsu_read(ram_addr(base_ram_lo, idx), fill_word(1'b0, idx), '1, 1'b1, rdata);
            lsu_write(ram_addr(base_ram_lo, idx), wdata, be_n);
            lsu_read(ram_addr(base_ram_lo, idx),
                     merge_bytes(fill_word(1'b0, idx), wdata, be_n), '1, 1'b1, rdata);
            chk_arb  <= 1'b0;
        end

        for (i = 0; i < n_ext; i++) begin
            idx   = sram_addr_w'($random(seed));
            wdata = $random(seed);
            be_n  = be_w'($random(seed));
            if (!ext_shadow.exists(idx)) ext_shadow[idx] = fill_word(1'b1, idx);
            ext_shadow[idx] = merge_bytes(ext_shadow[idx], wdata, be_n);
            ext_idx_q.push_back(idx);
            lsu_write(ram_addr(ext_ram_lo, idx), wdata, be_n);
        end
        foreach (ext_idx_q[k]) begin
            lsu_read(ram_addr(ext_ram_lo, ext_idx_q[k]), ext_shadow[ext_idx_q[k]], '1,
                     1'b1, rdata);
        end

        // byte out through the loopback and back into the buffer
        tx_byte = 8'($random(seed));
        lsu_write(uart_data_addr, {{(data_w-8){1'b0}}, tx_byte}, '0);
        do lsu_read(uart_stat_addr, '0, '0, 1'b0, rdata);
        while (!rdata[stat_rx_avail_bit]);
        lsu_read(uart_stat_addr, avail_mask, avail_mask, 1'b1, rdata);
        lsu_read(uart_data_addr, {{(data_w-8){1'b0}}, tx_byte}, 32'h0000_00ff, 1'b1, rdata);
        lsu_read(uart_stat_addr, '0, avail_mask, 1'b1, rdata);

        // back-to-back serial writes
        do lsu_read(uart_stat_addr, '0, '0, 1'b0, rdata);
        while (!rdata[stat_tx_ready_bit]);
        lsu_write(uart_data_addr, {{(data_w-8){1'b0}}, 8'($random(seed))}, '0);
        stalled_serial_write(8'($random(seed)));
        repeat (2) @(posedge clk);

        $display("summary: %0d errors in %0d accesses", errors, accesses);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, test sequence never completed",
                 watchdog_cycles);
        $display("summary: %0d errors in %0d accesses", errors, accesses);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
source/mem_bridge_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_regs.sv
source/mem_bridge.sv
source/soc_mem_top.sv
dv/tb_clk_gen.sv
dv/tb_soc_mem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_mem
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

check:
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "no pass in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
